//--- gf_pkg.sv
/*
 * GF(2^8) field definitions for the AES T-box lookup.
 * Holds the field byte type, the field constants and the basic
 * multiply and xtime operations used by the S-box and the T-boxes.
 */
`default_nettype none

package gf_pkg;

        // One element of GF(2^8) in polynomial basis.
        typedef logic [7:0] gf_byte_t;

        // Low byte of the AES reduction polynomial x^8 + x^4 + x^3 + x + 1.
        localparam gf_byte_t GF_POLY = 8'h1b;

        // Constant added at the end of the S-box affine transform.
        localparam gf_byte_t AFFINE_CONST = 8'h63;

        // Multiply by x, reducing when the top bit falls out.
        function automatic gf_byte_t gf_xtime(input gf_byte_t a);
                gf_byte_t shifted;
                shifted = {a[6:0], 1'b0};
                return a[7] ? (shifted ^ GF_POLY) : shifted;
        endfunction

        // Shift-and-add product of two field elements.
        function automatic gf_byte_t gf_mul(input gf_byte_t a, input gf_byte_t b);
                gf_byte_t acc;
                gf_byte_t x;
                acc = '0;
                x = a;
                for (int i = 0; i < 8; i++) begin
                        if (b[i]) begin
                                acc = acc ^ x;
                        end
                        x = gf_xtime(x);
                end
                return acc;
        endfunction

endpackage

`default_nettype wire

//--- lookup_pkg.sv
/*
 * Column and pipeline definitions for the T-box lookup.
 * Describes the 32-bit column word and the timing of the lookup stage.
 */
`default_nettype none

package lookup_pkg;

        // ====================================================================
        // Column layout
        // ====================================================================

        // One AES column or one T-box lookup word. Byte 0 sits in bits 31:24.
        typedef logic [31:0] word_t;

        // Number of bytes in one column.
        localparam logic [2:0] BYTES_PER_WORD = 3'd4;

        // ====================================================================
        // Pipeline timing
        // ====================================================================

        // Cycles from a sampled state word to its results on the outputs.
        // The S-box register is the only stage, so results and out_valid
        // appear at the same edge that samples state and in_valid.
        localparam logic [1:0] LOOKUP_LATENCY = 2'd1;

endpackage

`default_nettype wire

//--- gf_inverse.sv
/*
 * Multiplicative inverse in GF(2^8), combinational.
 * Raises the input to the 254th power, so zero maps to zero.
 */
`timescale 1ns/100ps
`default_nettype none

module gf_inverse (
        input  gf_pkg::gf_byte_t a,
        output gf_pkg::gf_byte_t inv
);

        import gf_pkg::*;

        // Powers of a along the addition chain 1, 2, 3, 6, 12, 15, 30, 60,
        // 120, 240, 252, 254.
        gf_byte_t a2;
        gf_byte_t a3;
        gf_byte_t a6;
        gf_byte_t a12;
        gf_byte_t a15;
        gf_byte_t a30;
        gf_byte_t a60;
        gf_byte_t a120;
        gf_byte_t a240;
        gf_byte_t a252;

        // ====================================================================
        // Build a^15 from small powers
        // ====================================================================

        assign a2  = gf_mul(a, a);
        assign a3  = gf_mul(a2, a);
        assign a6  = gf_mul(a3, a3);
        assign a12 = gf_mul(a6, a6);
        assign a15 = gf_mul(a12, a3);

        // ====================================================================
        // Four squarings lift a^15 to a^240
        // ====================================================================

        assign a30  = gf_mul(a15, a15);
        assign a60  = gf_mul(a30, a30);
        assign a120 = gf_mul(a60, a60);
        assign a240 = gf_mul(a120, a120);

        // a^254 is a^-1 for any nonzero a, since a^255 = 1 in the field.
        assign a252 = gf_mul(a240, a12);
        assign inv  = gf_mul(a252, a2);

endmodule

`default_nettype wire

//--- sbox.sv
/*
 * Registered AES S-box.
 * Field inverse followed by the affine transform, one cycle of latency.
 */
`timescale 1ns/100ps
`default_nettype none

module sbox (
        input  logic             clk,
        input  gf_pkg::gf_byte_t in_byte,
        output gf_pkg::gf_byte_t out_byte
);

        import gf_pkg::*;

        gf_byte_t inv;
        gf_byte_t rot1;
        gf_byte_t rot2;
        gf_byte_t rot3;
        gf_byte_t rot4;
        gf_byte_t affine;

        gf_inverse u_inv (
                .a   (in_byte),
                .inv (inv)
        );

        // Left rotations of the inverse. The affine matrix is circulant, so
        // each output bit is the XOR of five neighbouring inverse bits.
        assign rot1 = {inv[6:0], inv[7]};
        assign rot2 = {inv[5:0], inv[7:6]};
        assign rot3 = {inv[4:0], inv[7:5]};
        assign rot4 = {inv[3:0], inv[7:4]};

        assign affine = inv ^ rot1 ^ rot2 ^ rot3 ^ rot4 ^ AFFINE_CONST;

        always_ff @(posedge clk) begin
                out_byte <= affine;
        end

endmodule

`default_nettype wire

//--- t_box.sv
/*
 * One AES T-box.
 * Forms the lookup word {S, S, 3*S, 2*S} for one state byte.
 */
`timescale 1ns/100ps
`default_nettype none

module t_box (
        input  logic               clk,
        input  gf_pkg::gf_byte_t   in_byte,
        output lookup_pkg::word_t  t_word
);

        import gf_pkg::*;

        // Registered S-box value for this byte.
        gf_byte_t s;
        gf_byte_t s_x2;
        gf_byte_t s_x3;

        sbox u_sbox (
                .clk      (clk),
                .in_byte  (in_byte),
                .out_byte (s)
        );

        // The multiples are derived after the register, so the whole word
        // shares the single cycle of the S-box.
        assign s_x2 = gf_xtime(s);
        assign s_x3 = s ^ s_x2;

        // MixColumns coefficients 1, 1, 3 and 2, read from the top byte down.
        assign t_word = {s, s, s_x3, s_x2};

endmodule

`default_nettype wire

//--- tbox_lookup.sv
/*
 * Table lookup stage for one AES round on a 32-bit column.
 * Runs four T-boxes, rotates their words into place and also
 * returns the plain byte substitution. Latency is one cycle.
 */
`timescale 1ns/100ps
`default_nettype none

module tbox_lookup (
        input  logic              clk,
        input  logic              rst,
        input  logic              in_valid,
        input  lookup_pkg::word_t state,
        output logic              out_valid,
        output lookup_pkg::word_t p0,
        output lookup_pkg::word_t p1,
        output lookup_pkg::word_t p2,
        output lookup_pkg::word_t p3,
        output lookup_pkg::word_t sub_word
);

        import gf_pkg::*;
        import lookup_pkg::*;

        gf_byte_t b [BYTES_PER_WORD];
        word_t    t [BYTES_PER_WORD];

        // ====================================================================
        // T-boxes
        // ====================================================================

        // Byte b0 is the most significant byte of the column.
        assign {b[0], b[1], b[2], b[3]} = state;

        t_box t0 (.clk(clk), .in_byte(b[0]), .t_word(t[0]));
        t_box t1 (.clk(clk), .in_byte(b[1]), .t_word(t[1]));
        t_box t2 (.clk(clk), .in_byte(b[2]), .t_word(t[2]));
        t_box t3 (.clk(clk), .in_byte(b[3]), .t_word(t[3]));

        // ====================================================================
        // Output alignment
        // ====================================================================

        // Rotate right by one, two and three bytes; p3 stays as is.
        assign p0 = {t[0][7:0],  t[0][31:8]};
        assign p1 = {t[1][15:0], t[1][31:16]};
        assign p2 = {t[2][23:0], t[2][31:24]};
        assign p3 = t[3];

        // The top byte of every unrotated T-word is the S-box value itself.
        assign sub_word = {t[0][31:24], t[1][31:24], t[2][31:24], t[3][31:24]};

        // The valid flag follows the data through the single register stage.
        always_ff @(posedge clk) begin
                if (rst) begin
                        out_valid <= 1'b0;
                end else begin
                        out_valid <= in_valid;
                end
        end

endmodule

`default_nettype wire

//--- tb_tbox_lookup.sv
/*
 * Testbench for the AES T-box lookup stage.
 * Replays the vector file against the DUT and checks each result
 * one pipeline latency after its stimulus.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_tbox_lookup;

        import lookup_pkg::*;

        localparam int NUM_VECTORS    = 36;
        localparam int FIELDS         = 8;
        localparam int RESET_CYCLES   = 2;
        localparam int LATENCY        = int'(LOOKUP_LATENCY);
        localparam int TIMEOUT_CYCLES = NUM_VECTORS + RESET_CYCLES + 20;

        // Column positions inside one vector of the hex file.
        localparam int F_IN_VALID  = 0;
        localparam int F_STATE     = 1;
        localparam int F_EXP_VALID = 2;
        localparam int F_P0        = 3;
        localparam int F_P1        = 4;
        localparam int F_P2        = 5;
        localparam int F_P3        = 6;
        localparam int F_SUB       = 7;

        logic        clk;
        logic        rst;
        logic        in_valid;
        word_t       state;
        logic        out_valid;
        word_t       p0;
        word_t       p1;
        word_t       p2;
        word_t       p3;
        word_t       sub_word;
        logic [31:0] vectors [NUM_VECTORS * FIELDS];
        int          cycle_count = 0;

        tbox_lookup dut (
                .clk       (clk),
                .rst       (rst),
                .in_valid  (in_valid),
                .state     (state),
                .out_valid (out_valid),
                .p0        (p0),
                .p1        (p1),
                .p2        (p2),
                .p3        (p3),
                .sub_word  (sub_word)
        );

        initial begin
                clk = 1'b0;
                forever #2 clk = ~clk;
        end

        // ====================================================================
        // Run limit
        // ====================================================================

        always @(posedge clk) begin
                cycle_count <= cycle_count + 1;
                if (cycle_count >= TIMEOUT_CYCLES) begin
                        $display("Timeout: the run did not end within %0d cycles",
                                 TIMEOUT_CYCLES);
                        $display("Simulation failed");
                        $fatal(1, "Run stopped by the cycle limit");
                end
        end

        // ====================================================================
        // Helpers
        // ====================================================================

        task automatic compare_word(input string name, input logic [31:0] expected,
                                    input logic [31:0] actual);
                if (actual !== expected) begin
                        $display("[ERROR] t=%0t %s expected=%08h actual=%08h",
                                 $time, name, expected, actual);
                        $display("Simulation failed");
                        $fatal(1, "Output mismatch on %s", name);
                end
        endtask

        task automatic load_vectors();
                for (int k = 0; k < NUM_VECTORS * FIELDS; k++) begin
                        vectors[k] = ~32'(k);
                end
                $readmemh("tbox_vectors.hex", vectors);
                // Any valid column still holding its fill value means the file was short.
                for (int k = 0; k < NUM_VECTORS; k++) begin
                        if (vectors[k * FIELDS + F_IN_VALID] > 32'd1 ||
                            vectors[k * FIELDS + F_EXP_VALID] > 32'd1) begin
                                $display("The vector file is missing lines or has a bad valid column");
                                $display("Simulation failed");
                                $fatal(1, "Vector file could not be used");
                        end
                end
        endtask

        task automatic apply_vector(input int k);
                int base;
                base     = k * FIELDS;
                in_valid = vectors[base + F_IN_VALID][0];
                state    = vectors[base + F_STATE];
        endtask

        task automatic apply_idle();
                in_valid = 1'b0;
                state    = '0;
        endtask

        task automatic check_result(input int k);
                int base;
                base = k * FIELDS;
                compare_word("out_valid", vectors[base + F_EXP_VALID], {31'b0, out_valid});
                // Data outputs carry meaning only while out_valid is set.
                if (vectors[base + F_EXP_VALID][0]) begin
                        compare_word("p0", vectors[base + F_P0], p0);
                        compare_word("p1", vectors[base + F_P1], p1);
                        compare_word("p2", vectors[base + F_P2], p2);
                        compare_word("p3", vectors[base + F_P3], p3);
                        compare_word("sub_word", vectors[base + F_SUB], sub_word);
                end
        endtask

        // ====================================================================
        // Stimulus and checking
        // ====================================================================

        initial begin
                rst      = 1'b1;
                // Reset has to keep out_valid low even while in_valid is high.
                in_valid = 1'b1;
                state    = '0;
                load_vectors();
                repeat (RESET_CYCLES) @(posedge clk);
                @(negedge clk);
                rst = 1'b0;
                compare_word("out_valid", 32'h0, {31'b0, out_valid});

                // Vector i goes in at this falling edge; its result is checked
                // LATENCY falling edges later.
                for (int i = 0; i < NUM_VECTORS + LATENCY; i++) begin
                        if (i >= LATENCY) begin
                                check_result(i - LATENCY);
                        end
                        if (i < NUM_VECTORS) begin
                                apply_vector(i);
                        end else begin
                                apply_idle();
                        end
                        @(negedge clk);
                end

                $display("Simulation passed");
                $finish;
        end

endmodule

`default_nettype wire

//--- tbox_vectors.hex
// in_valid state exp_out_valid exp_p0 exp_p1 exp_p2 exp_p3 exp_sub_word
// Expected columns hold the result of the state on the same line.
0 00000000 0 00000000 00000000 00000000 00000000 00000000
1 000152ff 1 c66363a5 84f87c7c 00000000 16163a2c 637c0016
1 53535353 1 c1eded2c 2cc1eded ed2cc1ed eded2cc1 edededed
1 00000000 1 c66363a5 a5c66363 63a5c663 6363a5c6 63636363
1 ffffffff 1 2c16163a 3a2c1616 163a2c16 16163a2c 16161616
1 52525252 1 00000000 00000000 00000000 00000000 00000000
1 01010101 1 f87c7c84 84f87c7c 7c84f87c 7c7c84f8 7c7c7c7c
1 10203040 1 8fcaca45 c275b7b7 040c0804 09091b12 cab70409
1 40302010 1 1209091b 0c080404 b7c275b7 caca458f 0904b7ca
1 80112233 1 81cdcd4c 9d1f8282 93ae3d93 c3c35e9d cd8293c3
1 44556677 1 361b1b2d 1fe3fcfc 33556633 f5f504f1 1bfc33f5
1 8899aabb 1 93c4c457 29c7eeee acef43ac eaea25cf c4eeacea
1 ccddeeff 1 964b4bdd 5899c1c1 28785028 16163a2c 4bc12816
1 12345678 1 89c9c940 28301818 b1c879b1 bcbcdf63 c918b1bc
1 9abcdef0 1 6bb8b8d3 afca6565 1d273a1d 8c8c8f03 b8651d8c
0 a5a5a5a5 0 00000000 00000000 00000000 00000000 00000000
1 00ff5253 1 c66363a5 3a2c1616 00000000 eded2cc1 631600ed
0 00000000 0 00000000 00000000 00000000 00000000 00000000
0 5a5a5a5a 0 00000000 00000000 00000000 00000000 00000000
1 f0debc9a 1 038c8c8f 273a1d1d 65afca65 b8b8d36b 8c1d65b8
1 78563412 1 63bcbcdf c879b1b1 18283018 c9c94089 bcb118c9
0 ffffffff 0 00000000 00000000 00000000 00000000 00000000
1 33221180 1 9dc3c35e ae3d9393 829d1f82 cdcd4c81 c39382cd
0 00000000 0 00000000 00000000 00000000 00000000 00000000
1 77665544 1 f1f5f504 55663333 fc1fe3fc 1b1b2d36 f533fc1b
1 bbaa9988 1 cfeaea25 ef43acac ee29c7ee c4c45793 eaaceec4
0 12345678 0 00000000 00000000 00000000 00000000 00000000
0 00000000 0 00000000 00000000 00000000 00000000 00000000
0 a5a5a5a5 0 00000000 00000000 00000000 00000000 00000000
1 ffeeddcc 1 2c16163a 78502828 c15899c1 4b4bdd96 1628c14b
1 53520100 1 c1eded2c 00000000 7c84f87c 6363a5c6 ed007c63
1 01005352 1 f87c7c84 a5c66363 ed2cc1ed 00000000 7c63ed00
0 00000000 0 00000000 00000000 00000000 00000000 00000000
1 20304010 1 75b7b7c2 0c080404 091b1209 caca458f b70409ca
1 11223344 1 1f82829d ae3d9393 c35e9dc3 1b1b2d36 8293c31b
0 00000000 0 00000000 00000000 00000000 00000000 00000000

//--- flist.f
gf_pkg.sv
lookup_pkg.sv
gf_inverse.sv
sbox.sv
t_box.sv
tbox_lookup.sv
tb_tbox_lookup.sv

//--- Makefile
# Verilator flow for the AES T-box lookup stage.

VERILATOR  := verilator
TOP        := tb_tbox_lookup
RTL_TOP    := tbox_lookup
FILELIST   := flist.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -j 0
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "Result: PASS"; \
	else \
		echo "Result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
